// ==== src.f ====
src/l2_axi_pkg.sv
src/l2_axi_read_channel.sv
src/l2_axi_write_channel.sv
src/axi_burst_mem.sv
src/l2_axi_top.sv
test/l2_axi_checker.sv
test/tb_l2_axi.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator, run, then search the log for the failure line
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module tb_l2_axi -f src.f > build.log 2>&1 \
    || { echo "FAIL: build error, see build.log"; exit 1; }
./obj_dir/Vtb_l2_axi > sim.log 2>&1 || run_failed=1
grep -q "Done: errors found" sim.log && { echo "FAIL: see sim.log"; exit 1; }
[ -z "$run_failed" ] || { echo "FAIL: simulation stopped, see sim.log"; exit 1; }
echo "PASS"

// ==== test/tb_l2_axi.sv ====
//------------------------------------------------------------
// one read and one write burst in flight at most; only words
// written earlier are read back, watchdog at 2000 cycles
//------------------------------------------------------------
`default_nettype none

module tb_l2_axi;

    import l2_axi_pkg::*;

    localparam int WATCHDOG_CYCLES = 2000; // summed worst case plus margin

    logic        clk;
    logic        rstn;
    logic        l2_rvalid;
    l2_rd_req_t  l2_rd_req;
    logic        l2_raddr_ok;
    logic        l2_rready;
    logic        l2_rlast;
    data_t       l2_rdata;
    logic        l2_wvalid;
    l2_wr_req_t  l2_wr_req;
    logic        l2_wwvalid;
    l2_wr_beat_t l2_wbeat;
    logic        l2_waddr_ok;
    logic        l2_wready;
    logic        l2_bvalid;
    logic        l2_berr;
    logic        l2_bready;

    int    seed = 38;
    data_t ref_mem [MEM_WORDS];  // byte-merged image of the memory
    len_t  t2_len;
    len_t  t_len;

    l2_axi_top u_dut (
        .clk         (clk),
        .rstn        (rstn),
        .l2_rvalid   (l2_rvalid),
        .l2_rd_req   (l2_rd_req),
        .l2_raddr_ok (l2_raddr_ok),
        .l2_rready   (l2_rready),
        .l2_rlast    (l2_rlast),
        .l2_rdata    (l2_rdata),
        .l2_wvalid   (l2_wvalid),
        .l2_wr_req   (l2_wr_req),
        .l2_wwvalid  (l2_wwvalid),
        .l2_wbeat    (l2_wbeat),
        .l2_waddr_ok (l2_waddr_ok),
        .l2_wready   (l2_wready),
        .l2_bvalid   (l2_bvalid),
        .l2_berr     (l2_berr),
        .l2_bready   (l2_bready)
    );

    bind l2_axi_top l2_axi_checker u_chk (
        .clk         (clk),
        .rstn        (rstn),
        .ar          (ar),
        .arvalid     (arvalid),
        .arready     (arready),
        .aw          (aw),
        .awvalid     (awvalid),
        .awready     (awready),
        .w           (w),
        .wvalid      (wvalid),
        .wready      (wready),
        .l2_rready   (l2_rready),
        .l2_rlast    (l2_rlast),
        .l2_waddr_ok (l2_waddr_ok),
        .l2_bvalid   (l2_bvalid),
        .l2_bready   (l2_bready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("Done: errors found");
        $fatal(1, "simulation stopped by the watchdog");
    end

    task automatic check_eq(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
        assert (act === exp) else begin
            $display("error %s: expected %h, actual %h", name, exp, act);
            $display("Done: errors found");
            $fatal(1, "check failed");
        end
    endtask

    // memory word hit by a beat, 256 words from byte address bits 9..2
    function automatic int word_idx(input addr_t addr, input int beat);
        return ((addr >> 2) + beat) % MEM_WORDS;
    endfunction

    function automatic data_t merge_bytes(input data_t old_w, input data_t new_w,
                                          input strb_t strb);
        data_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    task automatic write_burst(input string name, input addr_t addr, input len_t len,
                               input bit rand_strb, input bit exp_err);
        int    beat;
        bit    done;
        data_t d;
        strb_t s;
        beat = 0;
        done = 1'b0;
        d    = $random(seed);
        s    = rand_strb ? strb_t'($random(seed)) : 4'hF;
        @(negedge clk);
        l2_wvalid = 1'b1;
        l2_wr_req = '{addr: addr, len: len, size: 3'd2};
        while (beat <= int'(len)) begin
            l2_wwvalid = ($random(seed) & 3) != 0; // some idle cycles
            l2_wbeat   = '{data: d, strb: s, last: (beat == int'(len))};
            @(posedge clk);
            if (l2_wwvalid && l2_wready) begin
                if (addr < ERR_BASE) begin
                    ref_mem[word_idx(addr, beat)] =
                        merge_bytes(ref_mem[word_idx(addr, beat)], d, s);
                end
                beat++;
                d = $random(seed);
                s = rand_strb ? strb_t'($random(seed)) : 4'hF;
            end
            @(negedge clk);
        end
        l2_wwvalid = 1'b0;
        l2_bready  = 1'b1;
        while (!done) begin
            @(posedge clk);
            if (l2_bvalid) begin
                check_eq({name, " berr"}, 32'(exp_err), 32'(l2_berr));
                done = 1'b1;
            end
        end
        @(negedge clk);
        l2_wvalid = 1'b0;
        l2_bready = 1'b0;
    endtask

    // expected words come from the model as it was when the read was issued
    task automatic read_burst(input string name, input addr_t addr, input len_t len);
        data_t snap [MEM_WORDS];
        data_t exp_w;
        int    beat;
        int    cycles;
        bit    done;
        snap   = ref_mem;
        beat   = 0;
        cycles = 0;
        done   = 1'b0;
        @(negedge clk);
        l2_rvalid = 1'b1;
        l2_rd_req = '{addr: addr, len: len, size: 3'd2};
        while (!done) begin
            @(posedge clk);
            cycles++;
            // one pulse, in the first data-phase cycle
            check_eq($sformatf("%s raddr_ok cycle %0d", name, cycles),
                     32'(cycles == 3), 32'(l2_raddr_ok));
            if (l2_rready) begin
                if (beat == 0) check_eq({name, " latency"}, 32'd3, 32'(cycles));
                exp_w = (addr >= ERR_BASE) ? ERR_WORD : snap[word_idx(addr, beat)];
                check_eq($sformatf("%s data beat %0d", name, beat), exp_w, l2_rdata);
                check_eq($sformatf("%s rlast beat %0d", name, beat),
                         32'(beat == int'(len)), 32'(l2_rlast));
                done = l2_rlast;
                beat++;
            end
        end
        @(negedge clk);
        l2_rvalid = 1'b0;
    endtask

    task automatic check_quiet(input string name);
        check_eq(name, 32'd0, 32'({l2_raddr_ok, l2_rready, l2_rlast,
                                   l2_waddr_ok, l2_wready, l2_bvalid}));
    endtask

    initial begin
        rstn       = 1'b0;
        l2_rvalid  = 1'b0;
        l2_rd_req  = '0;
        l2_wvalid  = 1'b0;
        l2_wr_req  = '0;
        l2_wwvalid = 1'b0;
        l2_wbeat   = '0;
        l2_bready  = 1'b0;

        repeat (5) begin
            @(negedge clk);
            check_quiet("reset quiet during reset");
        end
        rstn = 1'b1;
        @(negedge clk);
        check_quiet("reset quiet after reset");

        t2_len = len_t'($random(seed) & 15);
        write_burst("write then read, write", 32'h0000_0000, t2_len, 1'b0, 1'b0);
        read_burst("write then read, read", 32'h0000_0000, t2_len);

        // known words first, then strobed bytes over them
        write_burst("partial strobes, base", 32'h0000_0100, 8'd7, 1'b0, 1'b0);
        write_burst("partial strobes, merge", 32'h0000_0100, 8'd7, 1'b1, 1'b0);
        read_burst("partial strobes, read", 32'h0000_0100, 8'd7);

        t_len = len_t'($random(seed) & 15);
        read_burst("read error window", ERR_BASE, t_len);

        write_burst("write error window", ERR_BASE + 32'h100, 8'd7, 1'b0, 1'b1);
        read_burst("write error window, low range", 32'h0000_0100, 8'd7);

        t_len = len_t'($random(seed) & 15);
        fork
            read_burst("parallel read", 32'h0000_0000, t2_len);
            write_burst("parallel write", 32'h0000_0200, t_len, 1'b1, 1'b0);
        join
        read_burst("parallel write, read back", 32'h0000_0200, t_len);

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/l2_axi_checker.sv ====
//------------------------------------------------------------
// bound to l2_axi_top; assumes one burst per channel at a time
//------------------------------------------------------------
`default_nettype none

module l2_axi_checker (
    input logic                clk,
    input logic                rstn,
    input l2_axi_pkg::axi_ar_t ar,
    input logic                arvalid,
    input logic                arready,
    input l2_axi_pkg::axi_aw_t aw,
    input logic                awvalid,
    input logic                awready,
    input l2_axi_pkg::axi_w_t  w,
    input logic                wvalid,
    input logic                wready,
    input logic                l2_rready,
    input logic                l2_rlast,
    input logic                l2_waddr_ok,
    input logic                l2_bvalid,
    input logic                l2_bready
);

    import l2_axi_pkg::*;

    logic wlast_seen;   // last W beat taken, response still open

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wlast_seen <= 1'b0;
        end else if (wvalid && wready && w.last) begin
            wlast_seen <= 1'b1;
        end else if (l2_bvalid && l2_bready) begin
            wlast_seen <= 1'b0;
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (!rstn)
        arvalid && !arready |=> arvalid && $stable(ar))
        else $error("arvalid dropped or ar changed before arready");

    aw_hold: assert property (@(posedge clk) disable iff (!rstn)
        awvalid && !awready |=> awvalid && $stable(aw))
        else $error("awvalid dropped or aw changed before awready");

    rlast_with_beat: assert property (@(posedge clk) disable iff (!rstn)
        l2_rlast |-> l2_rready)
        else $error("l2_rlast seen without l2_rready");

    wvalid_in_data: assert property (@(posedge clk) disable iff (!rstn)
        wvalid |-> l2_waddr_ok)
        else $error("wvalid high outside the write data phase");

    bvalid_after_wlast: assert property (@(posedge clk) disable iff (!rstn)
        l2_bvalid |-> wlast_seen)
        else $error("l2_bvalid without a preceding last write beat");

endmodule

`default_nettype wire

// ==== src/l2_axi_top.sv ====
//------------------------------------------------------------
// L2 memory port with its own burst memory behind the bridge
//------------------------------------------------------------
`default_nettype none

module l2_axi_top (
    input  logic                    clk,
    input  logic                    rstn,
    // L2 refill
    input  logic                    l2_rvalid,
    input  l2_axi_pkg::l2_rd_req_t  l2_rd_req,
    output logic                    l2_raddr_ok,
    output logic                    l2_rready,
    output logic                    l2_rlast,
    output l2_axi_pkg::data_t       l2_rdata,
    // L2 writeback
    input  logic                    l2_wvalid,
    input  l2_axi_pkg::l2_wr_req_t  l2_wr_req,
    input  logic                    l2_wwvalid,
    input  l2_axi_pkg::l2_wr_beat_t l2_wbeat,
    output logic                    l2_waddr_ok,
    output logic                    l2_wready,
    output logic                    l2_bvalid,
    output logic                    l2_berr,
    input  logic                    l2_bready
);

    import l2_axi_pkg::*;

    axi_ar_t ar;
    logic    arvalid;
    logic    arready;
    axi_r_t  r;
    logic    rvalid;
    logic    rready;
    axi_aw_t aw;
    logic    awvalid;
    logic    awready;
    axi_w_t  w;
    logic    wvalid;
    logic    wready;
    resp_t   bresp;
    logic    bvalid;
    logic    bready;

    l2_axi_read_channel u_rd (
        .clk         (clk),
        .rstn        (rstn),
        .l2_rvalid   (l2_rvalid),
        .l2_rd_req   (l2_rd_req),
        .l2_raddr_ok (l2_raddr_ok),
        .l2_rready   (l2_rready),
        .l2_rlast    (l2_rlast),
        .l2_rdata    (l2_rdata),
        .ar          (ar),
        .arvalid     (arvalid),
        .arready     (arready),
        .r           (r),
        .rvalid      (rvalid),
        .rready      (rready)
    );

    l2_axi_write_channel u_wr (
        .clk         (clk),
        .rstn        (rstn),
        .l2_wvalid   (l2_wvalid),
        .l2_wr_req   (l2_wr_req),
        .l2_wwvalid  (l2_wwvalid),
        .l2_wbeat    (l2_wbeat),
        .l2_waddr_ok (l2_waddr_ok),
        .l2_wready   (l2_wready),
        .l2_bvalid   (l2_bvalid),
        .l2_berr     (l2_berr),
        .l2_bready   (l2_bready),
        .aw          (aw),
        .awvalid     (awvalid),
        .awready     (awready),
        .w           (w),
        .wvalid      (wvalid),
        .wready      (wready),
        .bresp       (bresp),
        .bvalid      (bvalid),
        .bready      (bready)
    );

    axi_burst_mem u_mem (
        .clk     (clk),
        .rstn    (rstn),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r),
        .rvalid  (rvalid),
        .rready  (rready),
        .aw      (aw),
        .awvalid (awvalid),
        .awready (awready),
        .w       (w),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready)
    );

endmodule

`default_nettype wire

// ==== src/axi_burst_mem.sv ====
//------------------------------------------------------------
// word beats only, size and burst type ignored; address wraps
// at MEM_WORDS, start address >= ERR_BASE gives SLVERR
//------------------------------------------------------------
`default_nettype none

module axi_burst_mem (
    input  logic                clk,
    input  logic                rstn,
    // AR / R
    input  l2_axi_pkg::axi_ar_t ar,
    input  logic                arvalid,
    output logic                arready,
    output l2_axi_pkg::axi_r_t  r,
    output logic                rvalid,
    input  logic                rready,
    // AW / W / B
    input  l2_axi_pkg::axi_aw_t aw,
    input  logic                awvalid,
    output logic                awready,
    input  l2_axi_pkg::axi_w_t  w,
    input  logic                wvalid,
    output logic                wready,
    output l2_axi_pkg::resp_t   bresp,
    output logic                bvalid,
    input  logic                bready
);

    import l2_axi_pkg::*;

    typedef enum logic [1:0] {
        WM_IDLE,
        WM_DATA,
        WM_RESP
    } wr_state_e;

    data_t mem [MEM_WORDS];

    logic                 rd_busy;
    logic                 rd_err;
    logic [MEM_IDX_W-1:0] rd_idx;
    len_t                 rd_cnt;   // beats left after this one

    wr_state_e            wr_state;
    logic                 wr_err;
    logic                 wr_room;  // still within len
    logic [MEM_IDX_W-1:0] wr_idx;
    len_t                 wr_cnt;
    logic                 wr_we;

    // read engine
    assign arready = !rd_busy;
    assign rvalid  = rd_busy;
    assign r = '{
        data: rd_err ? '0 : mem[rd_idx],
        resp: rd_err ? RESP_SLVERR : RESP_OKAY,
        last: (rd_cnt == '0)
    };

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_busy <= 1'b0;
            rd_err  <= 1'b0;
            rd_idx  <= '0;
            rd_cnt  <= '0;
        end else if (!rd_busy) begin
            if (arvalid) begin
                rd_busy <= 1'b1;
                rd_err  <= (ar.addr >= ERR_BASE);
                rd_idx  <= ar.addr[MEM_IDX_W+1:2];
                rd_cnt  <= ar.len;
            end
        end else if (rready) begin
            if (rd_cnt == '0) begin
                rd_busy <= 1'b0;
            end else begin
                rd_idx <= rd_idx + 1'b1;
                rd_cnt <= rd_cnt - 1'b1;
            end
        end
    end

    // write engine
    assign awready = (wr_state == WM_IDLE);
    assign wready  = (wr_state == WM_DATA);
    assign bvalid  = (wr_state == WM_RESP);
    assign bresp   = wr_err ? RESP_SLVERR : RESP_OKAY;
    assign wr_we   = wvalid && wready && !wr_err && wr_room;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_state <= WM_IDLE;
            wr_err   <= 1'b0;
            wr_room  <= 1'b0;
            wr_idx   <= '0;
            wr_cnt   <= '0;
        end else begin
            case (wr_state)
                WM_IDLE: begin
                    if (awvalid) begin
                        wr_state <= WM_DATA;
                        wr_err   <= (aw.addr >= ERR_BASE);
                        wr_room  <= 1'b1;
                        wr_idx   <= aw.addr[MEM_IDX_W+1:2];
                        wr_cnt   <= aw.len;
                    end
                end
                WM_DATA: begin
                    if (wvalid) begin
                        if (wr_cnt == '0) wr_room <= 1'b0; // extra beats dropped
                        wr_idx <= wr_idx + 1'b1;
                        wr_cnt <= wr_cnt - 1'b1;
                        if (w.last) wr_state <= WM_RESP;
                    end
                end
                WM_RESP: begin
                    if (bready) wr_state <= WM_IDLE;
                end
                default: wr_state <= WM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_we) begin
            for (int b = 0; b < $bits(strb_t); b++) begin
                if (w.strb[b]) mem[wr_idx][8*b +: 8] <= w.data[8*b +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/l2_axi_write_channel.sv ====
//------------------------------------------------------------
// one burst in flight; l2_wr_req must stay stable until the
// done handshake, and len must match the number of beats sent
//------------------------------------------------------------
`default_nettype none

module l2_axi_write_channel (
    input  logic                    clk,
    input  logic                    rstn,
    // L2 side
    input  logic                    l2_wvalid,
    input  l2_axi_pkg::l2_wr_req_t  l2_wr_req,
    input  logic                    l2_wwvalid,
    input  l2_axi_pkg::l2_wr_beat_t l2_wbeat,
    output logic                    l2_waddr_ok,
    output logic                    l2_wready,
    output logic                    l2_bvalid,
    output logic                    l2_berr,
    input  logic                    l2_bready,
    // AXI AW
    output l2_axi_pkg::axi_aw_t     aw,
    output logic                    awvalid,
    input  logic                    awready,
    // AXI W
    output l2_axi_pkg::axi_w_t      w,
    output logic                    wvalid,
    input  logic                    wready,
    // AXI B
    input  l2_axi_pkg::resp_t       bresp,
    input  logic                    bvalid,
    output logic                    bready
);

    import l2_axi_pkg::*;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_e;

    wr_state_e state;
    wr_state_e state_nxt;
    axi_aw_t   aw_req;
    axi_aw_t   aw_q;      // address as accepted by the slave
    logic      w_last_beat;
    logic      b_done;

    assign w_last_beat = wvalid && wready && w.last;
    assign b_done      = (state == WR_RESP) && bvalid && l2_bready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= WR_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (awvalid && awready) aw_q <= aw_req;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            WR_IDLE: begin
                if (l2_wvalid) state_nxt = WR_ADDR;
            end
            WR_ADDR: begin
                if (awready) state_nxt = WR_DATA;
            end
            WR_DATA: begin
                if (w_last_beat) state_nxt = WR_RESP;
            end
            WR_RESP: begin
                if (b_done) state_nxt = WR_IDLE;
            end
            default: state_nxt = WR_IDLE;
        endcase
    end

    assign aw_req = '{
        addr:  l2_wr_req.addr,
        len:   l2_wr_req.len,
        size:  l2_wr_req.size,
        burst: BURST_INCR
    };
    assign aw      = (state == WR_ADDR) ? aw_req : aw_q;
    assign awvalid = (state == WR_ADDR);

    // beats pass straight through, strobes included
    assign w = '{
        data: l2_wbeat.data,
        strb: l2_wbeat.strb,
        last: l2_wbeat.last
    };
    assign wvalid = (state == WR_DATA) && l2_wwvalid;

    assign l2_waddr_ok = (state == WR_DATA);
    assign l2_wready   = (state == WR_DATA) && wready;

    assign bready    = (state == WR_RESP) && l2_bready;
    assign l2_bvalid = (state == WR_RESP) && bvalid;
    assign l2_berr   = l2_bvalid && (bresp != RESP_OKAY); // SLVERR or DECERR

endmodule

`default_nettype wire

// ==== src/l2_axi_read_channel.sv ====
//------------------------------------------------------------
// one burst in flight; l2_rd_req must stay stable up to the
// beat with l2_rlast, and the L2 takes every beat offered
//------------------------------------------------------------
`default_nettype none

module l2_axi_read_channel (
    input  logic                   clk,
    input  logic                   rstn,
    // L2 side
    input  logic                   l2_rvalid,
    input  l2_axi_pkg::l2_rd_req_t l2_rd_req,
    output logic                   l2_raddr_ok,
    output logic                   l2_rready,
    output logic                   l2_rlast,
    output l2_axi_pkg::data_t      l2_rdata,
    // AXI AR
    output l2_axi_pkg::axi_ar_t    ar,
    output logic                   arvalid,
    input  logic                   arready,
    // AXI R
    input  l2_axi_pkg::axi_r_t     r,
    input  logic                   rvalid,
    output logic                   rready
);

    import l2_axi_pkg::*;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_e;

    rd_state_e state;
    rd_state_e state_nxt;
    logic      addr_ok_q;
    logic      beat;
    logic      beat_err;

    assign beat     = (state == RD_DATA) && rvalid;
    assign beat_err = (r.resp == RESP_SLVERR) || (r.resp == RESP_DECERR);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= RD_IDLE;
            addr_ok_q <= 1'b0;
        end else begin
            state     <= state_nxt;
            addr_ok_q <= (state == RD_ADDR) && arready; // one-cycle pulse
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            RD_IDLE: begin
                if (l2_rvalid) state_nxt = RD_ADDR;
            end
            RD_ADDR: begin
                if (arready) state_nxt = RD_DATA;
            end
            RD_DATA: begin
                if (rvalid && r.last) state_nxt = RD_IDLE;
            end
            default: state_nxt = RD_IDLE;
        endcase
    end

    // request is held by the L2, so the payload is stable under arvalid
    assign ar = '{
        addr:  l2_rd_req.addr,
        len:   l2_rd_req.len,
        size:  l2_rd_req.size,
        burst: BURST_INCR
    };
    assign arvalid = (state == RD_ADDR);

    // L2 never stalls the data phase
    assign rready = (state == RD_DATA);

    assign l2_raddr_ok = addr_ok_q;
    assign l2_rready   = beat;
    assign l2_rlast    = beat && r.last;
    assign l2_rdata    = beat_err ? ERR_WORD : r.data; // keep beat, swap data

endmodule

`default_nettype wire

// ==== src/l2_axi_pkg.sv ====
//------------------------------------------------------------
// 32-bit data only; bursts are INCR and one word per beat
//------------------------------------------------------------
`default_nettype none

package l2_axi_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [7:0]  len_t;   // beats minus one
    typedef logic [2:0]  size_t;
    typedef logic [1:0]  resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;
    localparam resp_t RESP_DECERR = 2'b11;

    localparam logic [1:0] BURST_INCR = 2'b01;

    // handed to the L2 for a failed read beat
    localparam data_t ERR_WORD = 32'hABCD_1234;

    localparam int    MEM_WORDS = 256;
    localparam int    MEM_IDX_W = $clog2(MEM_WORDS); // byte addr bits 9..2
    localparam addr_t ERR_BASE  = 32'h8000_0000;

    typedef struct packed {
        addr_t addr;
        len_t  len;
        size_t size;
    } l2_rd_req_t;

    typedef struct packed {
        addr_t addr;
        len_t  len;
        size_t size;
    } l2_wr_req_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
        logic  last;
    } l2_wr_beat_t;

    typedef struct packed {
        addr_t      addr;
        len_t       len;
        size_t      size;
        logic [1:0] burst;
    } axi_ar_t;

    typedef axi_ar_t axi_aw_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
        logic  last;
    } axi_w_t;

    typedef struct packed {
        data_t data;
        resp_t resp;
        logic  last;
    } axi_r_t;

endpackage

`default_nettype wire
